// ==== Bender.yml ====
package:
  name: attn_rescale

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/attn_pkg.sv
      - source/exp2_approx.sv
      - source/row_stat_tracker.sv
      - source/stat_fifo.sv
      - source/restoring_divider.sv
      - source/coef_update_unit.sv
      - source/attn_rescale_top.sv
      - target: test
        files:
          - verification/attn_rescale_assertions.sv
          - verification/tb_attn_rescale.sv

// ==== include/attn_config.svh ====
`ifndef ATTN_CONFIG_SVH
`define ATTN_CONFIG_SVH

// rows handled in one attention tile
`define ATTN_TILE_ROWS 4

// stat records the buffer between tracker and coefficient unit can hold
`define ATTN_FIFO_DEPTH 2

// one divider iteration per quotient bit
`define ATTN_DIV_STEPS 16

// most negative Q8.8 value as running max after reset or clear
`define ATTN_MAX_RESET 16'sh8000

`endif

// ==== source/attn_pkg.sv ====
`include "attn_config.svh"

package attn_pkg;

    typedef logic signed [15:0] max_t;   // Q8.8 signed row maximum
    typedef logic        [15:0] sum_t;   // Q8.8 unsigned exponential sum
    typedef logic        [15:0] frac_t;  // Q1.15 exponent, quotient, coefficient

    // statistics of one incoming score block
    typedef struct packed {
        max_t [`ATTN_TILE_ROWS-1:0] blk_max;
        sum_t [`ATTN_TILE_ROWS-1:0] blk_sum;
    } blk_stat_t;

    // old and new row statistics, one FIFO entry
    typedef struct packed {
        max_t [`ATTN_TILE_ROWS-1:0] m_old;
        max_t [`ATTN_TILE_ROWS-1:0] m_new;
        sum_t [`ATTN_TILE_ROWS-1:0] l_old;
        sum_t [`ATTN_TILE_ROWS-1:0] l_new;
    } row_stat_t;

    typedef frac_t [`ATTN_TILE_ROWS-1:0] coef_vec_t;
    typedef sum_t  [`ATTN_TILE_ROWS-1:0] sum_vec_t;

    typedef enum logic {
        DIV_IDLE,
        DIV_RUN
    } div_state_t;

    typedef enum logic [1:0] {
        COEF_IDLE,
        COEF_DIV,
        COEF_MUL
    } coef_state_t;

endpackage

// ==== source/attn_rescale_top.sv ====
`timescale 1ns/10ps

module attn_rescale_top (
    input  logic                I_CLK,
    input  logic                I_RST_N,
    input  logic                clear_i,
    input  logic                blk_vld_i,
    input  attn_pkg::blk_stat_t blk_stat_i,
    output logic                coef_vld_o,
    output attn_pkg::coef_vec_t coef_o,
    output attn_pkg::sum_vec_t  row_sum_o,
    output logic                overflow_o
);
    import attn_pkg::*;

    logic      push;
    row_stat_t rec;
    logic      pop;
    logic      not_empty;
    row_stat_t head;

    // producer
    row_stat_tracker i_row_stat_tracker (
        .I_CLK      (I_CLK),
        .I_RST_N    (I_RST_N),
        .clear_i    (clear_i),
        .blk_vld_i  (blk_vld_i),
        .blk_stat_i (blk_stat_i),
        .push_o     (push),
        .rec_o      (rec)
    );

    stat_fifo i_stat_fifo (
        .I_CLK       (I_CLK),
        .I_RST_N     (I_RST_N),
        .push_i      (push),
        .rec_i       (rec),
        .pop_i       (pop),
        .not_empty_o (not_empty),
        .head_o      (head),
        .overflow_o  (overflow_o)
    );

    // consumer
    coef_update_unit i_coef_update_unit (
        .I_CLK       (I_CLK),
        .I_RST_N     (I_RST_N),
        .not_empty_i (not_empty),
        .head_i      (head),
        .pop_o       (pop),
        .coef_vld_o  (coef_vld_o),
        .coef_o      (coef_o),
        .row_sum_o   (row_sum_o)
    );

endmodule

// ==== source/coef_update_unit.sv ====
`timescale 1ns/10ps
`include "attn_config.svh"

module coef_update_unit (
    input  logic                I_CLK,
    input  logic                I_RST_N,
    input  logic                not_empty_i,
    input  attn_pkg::row_stat_t head_i,
    output logic                pop_o,
    output logic                coef_vld_o,
    output attn_pkg::coef_vec_t coef_o,
    output attn_pkg::sum_vec_t  row_sum_o
);
    import attn_pkg::*;

    localparam int ROWS  = `ATTN_TILE_ROWS;
    localparam int STEPS = `ATTN_DIV_STEPS;
    localparam int CNT_W = $clog2(STEPS + 1);

    coef_state_t      state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             start_q;     // divider kick one cycle after pop
    logic             coef_vld_q;
    row_stat_t        rec_q;
    coef_vec_t        exp_v;
    coef_vec_t        quo_v;
    coef_vec_t        coef_d;
    coef_vec_t        coef_q;
    sum_vec_t         row_sum_q;

    assign pop_o = (state_q == COEF_IDLE) && not_empty_i;

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        logic [16:0] d;
        logic [31:0] prod;

        assign d = {rec_q.m_new[r][15], rec_q.m_new[r]} - {rec_q.m_old[r][15], rec_q.m_old[r]};

        // exp(m_old - m_new), settled long before the multiply
        exp2_approx i_exp (
            .I_CLK   (I_CLK),
            .I_RST_N (I_RST_N),
            .d_i     (d),
            .e_o     (exp_v[r])
        );

        // l_old / l_new
        restoring_divider i_div (
            .I_CLK      (I_CLK),
            .I_RST_N    (I_RST_N),
            .start_i    (start_q),
            .dividend_i (rec_q.l_old[r]),
            .divisor_i  (rec_q.l_new[r]),
            .quotient_o (quo_v[r])
        );

        assign prod      = exp_v[r] * quo_v[r] + 32'd16384;   // round to nearest
        assign coef_d[r] = (prod[31:15] > 17'd32767) ? 16'h7FFF : prod[30:15];
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            state_q    <= COEF_IDLE;
            cnt_q      <= '0;
            start_q    <= 1'b0;
            coef_vld_q <= 1'b0;
        end else begin
            start_q    <= 1'b0;
            coef_vld_q <= 1'b0;
            case (state_q)
                COEF_IDLE: begin
                    if (pop_o) begin
                        state_q <= COEF_DIV;
                        cnt_q   <= '0;
                        start_q <= 1'b1;
                    end
                end
                COEF_DIV: begin
                    // start cycle plus all divider steps
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(STEPS)) state_q <= COEF_MUL;
                end
                COEF_MUL: begin
                    // second cycle here is the valid pulse, pop waits for it
                    if (!coef_vld_q) coef_vld_q <= 1'b1;
                    else             state_q    <= COEF_IDLE;
                end
                default: state_q <= COEF_IDLE;
            endcase
        end
    end

    always_ff @(posedge I_CLK) begin
        if (pop_o) rec_q <= head_i;
        if (state_q == COEF_MUL && !coef_vld_q) begin
            coef_q    <= coef_d;
            row_sum_q <= rec_q.l_new;
        end
    end

    assign coef_vld_o = coef_vld_q;
    assign coef_o     = coef_q;
    assign row_sum_o  = row_sum_q;

endmodule

// ==== source/exp2_approx.sv ====
`timescale 1ns/10ps

module exp2_approx (
    input  logic            I_CLK,
    input  logic            I_RST_N,
    input  logic [16:0]     d_i,     // non-negative Q8.8 difference
    output attn_pkg::frac_t e_o
);
    import attn_pkg::*;

    logic [8:0]  n;        // integer part
    logic [7:0]  f;        // fraction
    logic [16:0] lin;
    logic [16:0] shifted;
    frac_t       e_q;

    assign n = d_i[16:8];
    assign f = d_i[7:0];

    // 2^-f approximated by 1 - f/2 in Q1.15
    assign lin     = 17'd32768 - {3'b000, f, 6'b000000};
    assign shifted = lin >> n[3:0];

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            e_q <= '0;
        end else begin
            e_q <= (n >= 9'd16) ? '0 : shifted[15:0];  // underflows to zero
        end
    end

    assign e_o = e_q;

endmodule

// ==== source/restoring_divider.sv ====
`timescale 1ns/10ps
`include "attn_config.svh"

module restoring_divider (
    input  logic            I_CLK,
    input  logic            I_RST_N,
    input  logic            start_i,
    input  attn_pkg::sum_t  dividend_i,
    input  attn_pkg::sum_t  divisor_i,
    output attn_pkg::frac_t quotient_o
);
    import attn_pkg::*;

    localparam int STEPS  = `ATTN_DIV_STEPS;
    localparam int STEP_W = $clog2(STEPS);

    div_state_t        state_q;
    logic [STEP_W-1:0] step_q;
    sum_t              divisor_q;
    sum_t              rem_q;
    frac_t             acc_q;       // numerator bits out, quotient bits in
    frac_t             quotient_q;
    logic              sat_q;       // l_old >= l_new means quotient >= 1.0
    logic              zero_q;
    logic [16:0]       trial;
    logic              fits;
    frac_t             acc_next;

    assign trial    = {rem_q, acc_q[15]};
    assign fits     = (trial >= {1'b0, divisor_q});
    assign acc_next = {acc_q[14:0], fits};

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            state_q    <= DIV_IDLE;
            step_q     <= '0;
            quotient_q <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_RUN;
                        step_q  <= '0;
                    end
                end
                DIV_RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == STEP_W'(STEPS - 1)) begin
                        state_q <= DIV_IDLE;
                        if (zero_q)     quotient_q <= '0;
                        else if (sat_q) quotient_q <= 16'h7FFF;
                        else            quotient_q <= acc_next;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    // numerator is dividend << 15, upper 15 bits preload the remainder
    always_ff @(posedge I_CLK) begin
        if (state_q == DIV_IDLE && start_i) begin
            divisor_q <= divisor_i;
            rem_q     <= {1'b0, dividend_i[15:1]};
            acc_q     <= {dividend_i[0], 15'd0};
            sat_q     <= (dividend_i >= divisor_i);
            zero_q    <= (divisor_i == '0);
        end else if (state_q == DIV_RUN) begin
            rem_q <= fits ? 16'(trial - {1'b0, divisor_q}) : trial[15:0];
            acc_q <= acc_next;
        end
    end

    assign quotient_o = quotient_q;

endmodule

// ==== source/row_stat_tracker.sv ====
`timescale 1ns/10ps
`include "attn_config.svh"

module row_stat_tracker (
    input  logic                I_CLK,
    input  logic                I_RST_N,
    input  logic                clear_i,
    input  logic                blk_vld_i,
    input  attn_pkg::blk_stat_t blk_stat_i,
    output logic                push_o,
    output attn_pkg::row_stat_t rec_o
);
    import attn_pkg::*;

    localparam int ROWS = `ATTN_TILE_ROWS;

    max_t  [ROWS-1:0] run_max_q;
    sum_vec_t         run_sum_q;
    max_t  [ROWS-1:0] m_new_d;
    max_t  [ROWS-1:0] m_new_q;
    sum_vec_t         blk_sum_q;
    sum_vec_t         l_new_d;
    frac_t [ROWS-1:0] e_run;
    frac_t [ROWS-1:0] e_blk;
    logic             s1_vld_q;   // exponents valid
    logic             push_q;
    row_stat_t        rec_q;

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        max_t        blk_max;
        max_t        run_max;
        logic [16:0] d_run;
        logic [16:0] d_blk;
        logic [31:0] run_term;
        logic [31:0] blk_term;
        logic [16:0] sum_full;

        assign blk_max    = blk_stat_i.blk_max[r];
        assign run_max    = run_max_q[r];
        assign m_new_d[r] = (blk_max > run_max) ? blk_max : run_max;

        // both differences are >= 0 by construction
        assign d_run = {m_new_d[r][15], m_new_d[r]} - {run_max[15], run_max};
        assign d_blk = {m_new_d[r][15], m_new_d[r]} - {blk_max[15], blk_max};

        exp2_approx i_exp_run (
            .I_CLK   (I_CLK),
            .I_RST_N (I_RST_N),
            .d_i     (d_run),
            .e_o     (e_run[r])
        );

        exp2_approx i_exp_blk (
            .I_CLK   (I_CLK),
            .I_RST_N (I_RST_N),
            .d_i     (d_blk),
            .e_o     (e_blk[r])
        );

        // cycle 1 rescale both sums and merge
        assign run_term   = run_sum_q[r] * e_run[r];
        assign blk_term   = blk_sum_q[r] * e_blk[r];
        assign sum_full   = run_term[31:15] + blk_term[31:15];
        assign l_new_d[r] = sum_full[16] ? 16'hFFFF : sum_full[15:0];
    end

    // clear also drops any block still in flight
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            s1_vld_q  <= 1'b0;
            push_q    <= 1'b0;
            run_max_q <= {ROWS{`ATTN_MAX_RESET}};
            run_sum_q <= '0;
        end else begin
            s1_vld_q <= blk_vld_i && !clear_i;
            push_q   <= s1_vld_q && !clear_i;
            if (clear_i) begin
                run_max_q <= {ROWS{`ATTN_MAX_RESET}};
                run_sum_q <= '0;
            end else if (s1_vld_q) begin
                run_max_q <= m_new_q;
                run_sum_q <= l_new_d;
            end
        end
    end

    always_ff @(posedge I_CLK) begin
        if (blk_vld_i) begin
            m_new_q   <= m_new_d;
            blk_sum_q <= blk_stat_i.blk_sum;
        end
        if (s1_vld_q) begin
            rec_q.m_old <= run_max_q;   // captured before running update
            rec_q.m_new <= m_new_q;
            rec_q.l_old <= run_sum_q;
            rec_q.l_new <= l_new_d;
        end
    end

    assign push_o = push_q;
    assign rec_o  = rec_q;

endmodule

// ==== source/stat_fifo.sv ====
`timescale 1ns/10ps
`include "attn_config.svh"

module stat_fifo (
    input  logic                I_CLK,
    input  logic                I_RST_N,
    input  logic                push_i,
    input  attn_pkg::row_stat_t rec_i,
    input  logic                pop_i,
    output logic                not_empty_o,
    output attn_pkg::row_stat_t head_o,
    output logic                overflow_o
);
    import attn_pkg::*;

    localparam int DEPTH = `ATTN_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    row_stat_t        mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             do_push;
    logic             do_pop;
    logic             overflow_q;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (count_q == CNT_W'(DEPTH));
    assign do_pop  = pop_i && (count_q != '0);
    assign do_push = push_i && (!full || do_pop);   // full but draining is fine

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            if (push_i && !do_push) overflow_q <= 1'b1;   // sticky until reset
        end
    end

    always_ff @(posedge I_CLK) begin
        if (do_push) mem_q[wr_ptr_q] <= rec_i;
    end

    assign not_empty_o = (count_q != '0);
    assign head_o      = mem_q[rd_ptr_q];
    assign overflow_o  = overflow_q;

endmodule

// ==== tb.f ====
+incdir+include
source/attn_pkg.sv
source/exp2_approx.sv
source/row_stat_tracker.sv
source/stat_fifo.sv
source/restoring_divider.sv
source/coef_update_unit.sv
source/attn_rescale_top.sv
verification/attn_rescale_assertions.sv
verification/tb_attn_rescale.sv

// ==== verification/attn_rescale_assertions.sv ====
`timescale 1ns/10ps
`include "attn_config.svh"

module attn_rescale_assertions (
    input logic                                   I_CLK,
    input logic                                   I_RST_N,
    input logic                                   pulse_i,     // result valid strobe
    input logic [$clog2(`ATTN_FIFO_DEPTH+1)-1:0] count_i,     // FIFO occupancy
    input logic                                   pop_i,
    input logic                                   overflow_i
);

    int unsigned fail_cnt = 0;

    a_single_pulse: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        pulse_i |=> !pulse_i)
        else begin
            $error("coef_vld_o stayed high for more than one cycle");
            fail_cnt++;
        end

    a_count_bound: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        count_i <= `ATTN_FIFO_DEPTH)
        else begin
            $error("FIFO count above its depth");
            fail_cnt++;
        end

    a_no_empty_pop: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        pop_i |-> count_i != '0)
        else begin
            $error("pop while the FIFO is empty");
            fail_cnt++;
        end

    // overflow is sticky until reset
    a_sticky_overflow: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        overflow_i |=> overflow_i)
        else begin
            $error("overflow_o fell without a reset");
            fail_cnt++;
        end

endmodule

bind stat_fifo attn_rescale_assertions i_fifo_chk (
    .I_CLK      (I_CLK),
    .I_RST_N    (I_RST_N),
    .pulse_i    (1'b0),
    .count_i    (count_q),
    .pop_i      (pop_i),
    .overflow_i (overflow_o)
);

bind coef_update_unit attn_rescale_assertions i_coef_chk (
    .I_CLK      (I_CLK),
    .I_RST_N    (I_RST_N),
    .pulse_i    (coef_vld_o),
    .count_i    ('0),
    .pop_i      (1'b0),
    .overflow_i (1'b0)
);

// ==== verification/tb_attn_rescale.sv ====
`timescale 1ns/10ps
`include "attn_config.svh"

module tb_attn_rescale;
    import attn_pkg::*;

    localparam int ROWS = `ATTN_TILE_ROWS;

    logic        I_CLK;
    logic        I_RST_N;
    logic        clear_i;
    logic        blk_vld_i;
    blk_stat_t   blk_stat_i;
    logic        coef_vld_o;
    coef_vec_t   coef_o;
    sum_vec_t    row_sum_o;
    logic        overflow_o;

    logic [31:0] lcg_state;
    int          cyc;            // falling edges seen so far
    int          n_res;
    int          res_cyc;        // falling edge of the last result
    int          m_run [ROWS];   // model running max
    longint      l_run [ROWS];   // model running sum
    coef_vec_t   coef_q [$];     // expected results in output order
    sum_vec_t    sum_q [$];
    int          fifo_push [$];  // push edges of records held in the model FIFO
    int          free_edge;      // first edge the consumer may pop again
    string       test_name;

    attn_rescale_top i_attn_rescale_top (
        .I_CLK      (I_CLK),
        .I_RST_N    (I_RST_N),
        .clear_i    (clear_i),
        .blk_vld_i  (blk_vld_i),
        .blk_stat_i (blk_stat_i),
        .coef_vld_o (coef_vld_o),
        .coef_o     (coef_o),
        .row_sum_o  (row_sum_o),
        .overflow_o (overflow_o)
    );

    initial begin
        I_CLK = 1'b0;
        forever #5 I_CLK = ~I_CLK;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // linear base-2 rule, d in Q8.8
    function automatic int exp2_neg(int d);
        if (d >= 16 * 256) return 0;
        return (32768 - 64 * (d % 256)) >> (d / 256);
    endfunction

    function automatic int assertion_fails();
        return i_attn_rescale_top.i_stat_fifo.i_fifo_chk.fail_cnt
             + i_attn_rescale_top.i_coef_update_unit.i_coef_chk.fail_cnt;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_coef(coef_vec_t exp_v, coef_vec_t act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("Mismatch in %s: coef expected %h, actual %h",
                               test_name, exp_v, act_v));
    endtask

    task automatic check_sum(sum_vec_t exp_v, sum_vec_t act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("Mismatch in %s: row sum expected %h, actual %h",
                               test_name, exp_v, act_v));
    endtask

    task automatic check_flag(logic exp_v, logic act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("Mismatch in %s: overflow expected %b, actual %b",
                               test_name, exp_v, act_v));
    endtask

    task automatic check_latency(int exp_v, int act_v);
        if (act_v != exp_v)
            fail_run($sformatf("Mismatch in %s: latency expected %0d, actual %0d",
                               test_name, exp_v, act_v));
    endtask

    task automatic reset_model();
        for (int r = 0; r < ROWS; r++) begin
            m_run[r] = `ATTN_MAX_RESET;
            l_run[r] = 0;
        end
    endtask

    // expected record for one block, then FIFO occupancy by the fixed timing
    task automatic model_block(blk_stat_t blk, int edge_idx);
        coef_vec_t coef;
        sum_vec_t  sums;
        max_t      bm;
        int        m_new;
        int        e;
        int        push_edge;
        int        pop_edge;
        longint    l_new;
        longint    q;
        longint    c;
        for (int r = 0; r < ROWS; r++) begin
            bm    = max_t'(blk.blk_max[r]);
            m_new = (bm > m_run[r]) ? bm : m_run[r];
            e     = exp2_neg(m_new - m_run[r]);
            l_new = (l_run[r] * e) >> 15;
            l_new += (longint'(blk.blk_sum[r]) * exp2_neg(m_new - bm)) >> 15;
            if (l_new > 65535) l_new = 65535;
            q = (l_new == 0) ? 0 : (l_run[r] << 15) / l_new;
            if (q > 32767) q = 32767;
            c = (e * q + 16384) >> 15;
            if (c > 32767) c = 32767;
            coef[r]  = frac_t'(c);
            sums[r]  = sum_t'(l_new);
            m_run[r] = m_new;
            l_run[r] = l_new;
        end
        push_edge = edge_idx + 2;
        // pulse 19 cycles after a pop, next pop one cycle later
        while (fifo_push.size() > 0) begin
            pop_edge = (free_edge > fifo_push[0] + 1) ? free_edge : fifo_push[0] + 1;
            if (pop_edge > push_edge) break;
            void'(fifo_push.pop_front());
            free_edge = pop_edge + 20;
        end
        if (fifo_push.size() < `ATTN_FIFO_DEPTH) begin
            fifo_push.push_back(push_edge);
            coef_q.push_back(coef);
            sum_q.push_back(sums);
        end
    endtask

    function automatic blk_stat_t rand_block();
        blk_stat_t blk;
        int        v;
        for (int r = 0; r < ROWS; r++) begin
            v = m_run[r] + int'(next_random() % 1280) - 1024;   // -4.0 .. +1.0
            if (v < -32768) v = -32768;
            if (v > 32767) v = 32767;
            blk.blk_max[r] = max_t'(v);
            blk.blk_sum[r] = sum_t'(next_random() >> 20);
        end
        return blk;
    endfunction

    function automatic blk_stat_t uniform_block(max_t bmax, sum_t bsum);
        blk_stat_t blk;
        for (int r = 0; r < ROWS; r++) begin
            blk.blk_max[r] = bmax;
            blk.blk_sum[r] = bsum;
        end
        return blk;
    endfunction

    // every falling edge passes here, results are checked as they appear
    task automatic step_cycle();
        @(negedge I_CLK);
        cyc++;
        if (assertion_fails() != 0) fail_run("A concurrent assertion on the DUT failed");
        if (coef_vld_o === 1'b1) begin
            if (coef_q.size() == 0)
                fail_run($sformatf("Unexpected coef_vld_o pulse in %s", test_name));
            check_coef(coef_q.pop_front(), coef_o);
            check_sum(sum_q.pop_front(), row_sum_o);
            n_res++;
            res_cyc = cyc;
        end
    endtask

    task automatic idle(int n);
        repeat (n) step_cycle();
    endtask

    task automatic wait_result();
        int start;
        start = n_res;
        for (int i = 0; i < 100; i++) begin
            step_cycle();
            if (n_res != start) return;
        end
        fail_run($sformatf("Timed out waiting for coef_vld_o in %s", test_name));
    endtask

    task automatic wait_drain();
        while (coef_q.size() > 0) wait_result();
    endtask

    task automatic issue_block(blk_stat_t blk);
        blk_vld_i  = 1'b1;
        blk_stat_i = blk;
        model_block(blk, cyc);
        step_cycle();
        blk_vld_i  = 1'b0;
    endtask

    task automatic run_block(blk_stat_t blk);
        issue_block(blk);
        wait_drain();
        idle(3);
    endtask

    task automatic pulse_clear();
        clear_i = 1'b1;
        reset_model();
        step_cycle();
        clear_i = 1'b0;
    endtask

    initial begin
        blk_stat_t blk;
        int        t0;
        lcg_state  = 32'h4101;
        I_RST_N    = 1'b0;
        clear_i    = 1'b0;
        blk_vld_i  = 1'b0;
        blk_stat_i = '0;
        cyc        = 0;
        n_res      = 0;
        res_cyc    = 0;
        free_edge  = 0;
        test_name  = "reset";
        reset_model();
        repeat (2) step_cycle();
        I_RST_N = 1'b1;
        idle(3);

        // empty pipeline, first block after reset
        test_name = "first_block";
        blk = rand_block();
        t0  = cyc;
        issue_block(blk);
        wait_result();
        check_latency(22, res_cyc - t0);
        check_coef('0, coef_o);
        check_sum(blk.blk_sum, row_sum_o);
        idle(3);

        for (int i = 0; i < 200; i++) begin
            test_name = "random_stream";
            if (i == 100) begin
                test_name = "clear_restart";
                pulse_clear();
                idle(2);
            end
            blk = rand_block();
            issue_block(blk);
            wait_drain();
            if (i == 100) begin
                check_coef('0, coef_o);
                check_sum(blk.blk_sum, row_sum_o);
            end
            idle(3 + int'(next_random() % 4));
        end

        test_name = "edge_values";
        pulse_clear();
        run_block(uniform_block(16'sh0000, 16'h0000));
        run_block(uniform_block(16'sh0000, 16'h0000));
        check_coef('0, coef_o);
        check_sum('0, row_sum_o);
        run_block(uniform_block(16'sh0000, 16'hFFFF));
        run_block(uniform_block(16'sh0000, 16'hFFFF));
        check_sum({ROWS{16'hFFFF}}, row_sum_o);
        check_coef({ROWS{16'h7FFF}}, coef_o);
        run_block(uniform_block(16'sh1400, 16'h0100));   // max jumps by 20.0
        check_coef('0, coef_o);
        check_sum({ROWS{16'h0100}}, row_sum_o);

        test_name = "burst_3";
        repeat (3) begin
            issue_block(rand_block());
            idle(2);
        end
        wait_drain();
        check_flag(1'b0, overflow_o);
        idle(3);

        test_name = "burst_6";
        repeat (6) begin
            issue_block(rand_block());
            idle(2);
        end
        wait_drain();
        check_flag(1'b1, overflow_o);
        idle(40);   // dropped records must not show up

        if (assertion_fails() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule
